// ==== compile.f ====
verilog/dmaPkg.sv
verilog/dmaSequencer.sv
verilog/dmaAddressPath.sv
verilog/dmaChannel.sv
verilog/dmaBusArbiter.sv
verilog/dmaController.sv
+incdir+include
tests/dmaControllerTb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DMA controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dmaControllerTb \
  -f compile.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation returned an error, see sim.log"
fi

if grep -qx "PASS: all tests" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== include/dmaTbChecks.svh ====
`ifndef DMA_TB_CHECKS_SVH
`define DMA_TB_CHECKS_SVH

// unwritten memory reads back a pattern built from the whole halfword address
function automatic logic [15:0] fillHalf(int k);
  return 16'(k ^ (k >>> 16)) ^ 16'h5a3c;
endfunction

function automatic logic [15:0] memHalf(dmaPkg::dmaAddr_t a);
  int k;
  k = int'(a >> 1);
  return mem.exists(k) ? mem[k] : fillHalf(k);
endfunction

function automatic dmaPkg::dmaAddr_t stepBy(dmaPkg::dmaAddr_t a, dmaPkg::stepMode_t m,
                                           int bytes);
  if (m == dmaPkg::stepDec) return a - dmaPkg::dmaAddr_t'(bytes);
  if (m == dmaPkg::stepFixed) return a;
  return a + dmaPkg::dmaAddr_t'(bytes);
endfunction

// walks the copy by the stepping rules; dst holds still after the last unit of a pass
task automatic predict(dmaPkg::dmaCfg_t c, int passes);
  dmaPkg::dmaAddr_t s;
  dmaPkg::dmaAddr_t d;
  int bytes;
  int k;
  s = c.srcAddr;
  d = c.dstAddr;
  bytes = c.wordUnits ? 4 : 2;
  for (int p = 0; p < passes; p++) begin
    if (p > 0 && c.dstStep == dmaPkg::stepIncReload) d = c.dstAddr;
    for (int i = 0; i < int'(c.wordCount); i++) begin
      k = int'(d >> 1);
      for (int h = 0; h < bytes / 2; h++) begin
        expMem[k + h] = memHalf(s + dmaPkg::dmaAddr_t'(2 * h));
        expCount[k + h] = expCount.exists(k + h) ? expCount[k + h] + 1 : 1;
        expTotal++;
      end
      s = stepBy(s, c.srcStep, bytes);
      if (i < int'(c.wordCount) - 1) d = stepBy(d, c.dstStep, bytes);
    end
  end
endtask

task automatic abortRun();
  $display("FAIL: see errors above");
  $fatal(1);
endtask

task automatic checkWord(string name, dmaPkg::dmaWord_t exp, dmaPkg::dmaWord_t act);
  if (exp !== act) begin
    $display("ERR %s expected %h actual %h", name, exp, act);
    abortRun();
  end
endtask

task automatic checkAddr(string name, dmaPkg::dmaAddr_t exp, dmaPkg::dmaAddr_t act);
  if (exp !== act) begin
    $display("ERR %s expected %h actual %h", name, exp, act);
    abortRun();
  end
endtask

task automatic checkCount(string name, dmaPkg::unitCount_t exp, dmaPkg::unitCount_t act);
  if (exp !== act) begin
    $display("ERR %s expected %0d actual %0d", name, exp, act);
    abortRun();
  end
endtask

task automatic verifyMemory(string name);
  foreach (expMem[k]) begin
    checkWord({name, " data"}, dmaPkg::dmaWord_t'(expMem[k]), dmaPkg::dmaWord_t'(memHalf(
      dmaPkg::dmaAddr_t'(k) << 1)));
  end
  foreach (expCount[k]) begin
    checkCount({name, " writes per address"}, dmaPkg::unitCount_t'(expCount[k]),
      dmaPkg::unitCount_t'(writeCount.exists(k) ? writeCount[k] : 0));
  end
  checkCount({name, " total writes"}, dmaPkg::unitCount_t'(expTotal),
    dmaPkg::unitCount_t'(totalWrites));
endtask

`endif

// ==== tests/dmaControllerTb.sv ====
`timescale 1ns/1ns

module dmaControllerTb;

  logic clk;
  logic rst_b;
  dmaPkg::dmaCfg_t cfg [dmaPkg::numChannels];
  dmaPkg::screenPos_t hcount;
  dmaPkg::screenPos_t vcount;
  logic memWait;
  dmaPkg::dmaWord_t rdata;
  dmaPkg::busReq_t bus;
  logic busActive;
  logic [dmaPkg::numChannels-1:0] irq;
  logic [dmaPkg::numChannels-1:0] done;
  logic [dmaPkg::numChannels-1:0] active;

  logic [15:0] mem [int];       // halfword memory keyed by addr >> 1
  logic [15:0] expMem [int];
  int writeCount [int];
  int expCount [int];
  int totalWrites;
  int expTotal;
  int irqCount [dmaPkg::numChannels];
  int doneCount [dmaPkg::numChannels];
  int doneOrder [$];
  logic [dmaPkg::numChannels-1:0] clearPending;
  logic sweepEn;
  logic waitEn;

  `include "dmaTbChecks.svh"

  dmaController i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // memory answers in the same cycle
  always_comb begin
    if (bus.size == dmaPkg::sizeWord) rdata = {memHalf(bus.addr + 28'd2), memHalf(bus.addr)};
    else rdata = {16'h0, memHalf(bus.addr)};
  end

  always @(posedge clk) begin
    memWait <= waitEn && ($urandom_range(3) == 0);
    if (sweepEn) begin
      hcount <= hcount + 8'd1;
      if (hcount == 8'd255) vcount <= (vcount == 8'd227) ? 8'd0 : vcount + 8'd1;
    end else begin
      hcount <= 8'd0;
      vcount <= 8'd0;
    end
    for (int i = 0; i < dmaPkg::numChannels; i++) begin
      if (clearPending[i]) begin
        cfg[i].enable <= 1'b0; // software clears enable after done
      end
    end
  end

  task automatic recordWrite();
    int k;
    int n;
    k = int'(bus.addr >> 1);
    n = (bus.size == dmaPkg::sizeWord) ? 2 : 1;
    if (n == 2) begin
      mem[k] = bus.wdata[15:0];
      mem[k + 1] = bus.wdata[31:16];
    end else begin
      mem[k] = bus.addr[1] ? bus.wdata[31:16] : bus.wdata[15:0]; // lane by addr bit 1
    end
    for (int h = 0; h < n; h++) begin
      writeCount[k + h] = writeCount.exists(k + h) ? writeCount[k + h] + 1 : 1;
      totalWrites++;
    end
  endtask

  // outputs settle by the falling edge
  always @(negedge clk) begin
    if (rst_b) begin
      if (bus.wen) begin
        // a write cycle belongs to exactly one channel
        checkCount("channels active in a write", 14'd1,
          dmaPkg::unitCount_t'($countones(active)));
        checkCount("busActive in a write", 14'd1, dmaPkg::unitCount_t'(busActive));
        if (!memWait) recordWrite();
      end
      clearPending = done;
      for (int i = 0; i < dmaPkg::numChannels; i++) begin
        if (irq[i]) irqCount[i]++;
        if (done[i]) begin
          doneCount[i]++;
          doneOrder.push_back(i);
        end
      end
    end
  end

  function automatic dmaPkg::dmaCfg_t makeCfg(logic word, dmaPkg::startMode_t sm,
      dmaPkg::stepMode_t ss, dmaPkg::stepMode_t ds, logic irqEn, logic rep, int len,
      dmaPkg::dmaAddr_t src, dmaPkg::dmaAddr_t dst);
    dmaPkg::dmaCfg_t c;
    c = '0;
    c.enable = 1'b1;
    c.irqEnable = irqEn;
    c.repeatEn = rep;
    c.wordUnits = word;
    c.startMode = sm;
    c.srcStep = ss;
    c.dstStep = ds;
    c.wordCount = dmaPkg::unitCount_t'(len);
    c.srcAddr = src;
    c.dstAddr = dst;
    return c;
  endfunction

  task automatic clearTracking();
    expMem.delete();
    expCount.delete();
    writeCount.delete();
    doneOrder.delete();
    totalWrites = 0;
    expTotal = 0;
    for (int i = 0; i < dmaPkg::numChannels; i++) begin
      irqCount[i] = 0;
      doneCount[i] = 0;
    end
  endtask

  task automatic fillSource(dmaPkg::dmaAddr_t a);
    for (int i = -128; i < 128; i++) mem[int'(a >> 1) + i] = 16'($urandom);
  endtask

  task automatic waitDone(int ch, int limit);
    int n;
    n = 0;
    while (doneCount[ch] < 1) begin
      @(posedge clk);
      n++;
      if (n > limit) begin
        $display("timeout: channel %0d never finished its transfer", ch);
        abortRun();
      end
    end
    repeat (20) @(posedge clk); // let any stray cycle show up
  endtask

  task automatic waitIrqs(int ch, int target, int limit);
    int n;
    n = 0;
    while (irqCount[ch] < target) begin
      @(posedge clk);
      n++;
      if (n > limit) begin
        $display("timeout: channel %0d gave too few interrupts", ch);
        abortRun();
      end
    end
  endtask

  task automatic runCopy(string name, int ch, dmaPkg::dmaCfg_t c);
    clearTracking();
    fillSource(c.srcAddr);
    predict(c, 1);
    @(posedge clk);
    cfg[ch] <= c;
    waitDone(ch, 20000);
    verifyMemory(name);
    checkCount({name, " irq"}, dmaPkg::unitCount_t'(c.irqEnable),
      dmaPkg::unitCount_t'(irqCount[ch]));
    checkCount({name, " done"}, 14'd1, dmaPkg::unitCount_t'(doneCount[ch]));
  endtask

  initial begin
    dmaPkg::dmaCfg_t a;
    dmaPkg::dmaCfg_t b;
    void'($urandom(96142));
    rst_b = 1'b0;
    for (int i = 0; i < dmaPkg::numChannels; i++) cfg[i] = '0;
    hcount = '0;
    vcount = '0;
    memWait = 1'b0;
    clearPending = '0;
    sweepEn = 1'b1;
    waitEn = 1'b0;
    clearTracking();
    repeat (4) @(posedge clk);
    rst_b <= 1'b1;
    waitEn <= 1'b1;

    a = makeCfg(1'b1, dmaPkg::startNow, dmaPkg::stepInc, dmaPkg::stepInc, 1'b1, 1'b0,
      1 + int'($urandom_range(15)), 28'h010_0000 + 28'($urandom_range(63)) * 28'd4,
      28'h020_0000);
    runCopy("word copy", 1, a);

    // destination sits in the upper lane
    a = makeCfg(1'b0, dmaPkg::startNow, dmaPkg::stepDec, dmaPkg::stepFixed, 1'b0, 1'b0,
      1 + int'($urandom_range(15)), 28'h030_0200,
      28'h040_0002 + 28'($urandom_range(7)) * 28'd4);
    runCopy("half copy", 2, a);

    @(posedge clk);
    sweepEn <= 1'b0; // hold the screen at line 0, column 0
    a = makeCfg(1'b1, dmaPkg::startHblank, dmaPkg::stepInc, dmaPkg::stepInc, 1'b1, 1'b0,
      1 + int'($urandom_range(15)), 28'h050_0000, 28'h060_0000);
    clearTracking();
    fillSource(a.srcAddr);
    predict(a, 1);
    @(posedge clk);
    cfg[1] <= a;
    repeat (100) @(posedge clk);
    checkCount("hblank early writes", 14'd0, dmaPkg::unitCount_t'(totalWrites));
    sweepEn <= 1'b1;
    waitDone(1, 20000);
    verifyMemory("hblank copy");

    @(posedge clk);
    sweepEn <= 1'b0;
    a = makeCfg(1'b0, dmaPkg::startVblank, dmaPkg::stepInc, dmaPkg::stepInc, 1'b1, 1'b0,
      1 + int'($urandom_range(15)), 28'h070_0000, 28'h080_0000);
    clearTracking();
    fillSource(a.srcAddr);
    predict(a, 1);
    @(posedge clk);
    cfg[2] <= a;
    repeat (100) @(posedge clk);
    checkCount("vblank early writes", 14'd0, dmaPkg::unitCount_t'(totalWrites));
    sweepEn <= 1'b1;
    waitDone(2, 100000);
    verifyMemory("vblank copy");

    clearTracking();
    a = makeCfg(1'b1, dmaPkg::startSpecial, dmaPkg::stepInc, dmaPkg::stepInc, 1'b1, 1'b0,
      4, 28'h090_0000, 28'h0a0_0000);
    @(posedge clk);
    cfg[3] <= a;
    repeat (600) @(posedge clk);
    checkCount("special mode writes", 14'd0, dmaPkg::unitCount_t'(totalWrites));
    cfg[3].enable <= 1'b0;
    repeat (4) @(posedge clk);

    a = makeCfg(1'b1, dmaPkg::startNow, dmaPkg::stepInc, dmaPkg::stepInc, 1'b0, 1'b0,
      1 + int'($urandom_range(15)), 28'h0b0_0000, 28'h0c0_0000);
    b = makeCfg(1'b0, dmaPkg::startNow, dmaPkg::stepInc, dmaPkg::stepInc, 1'b1, 1'b0,
      1 + int'($urandom_range(15)), 28'h0d0_0000, 28'h0e0_0000);
    clearTracking();
    fillSource(a.srcAddr);
    fillSource(b.srcAddr);
    predict(a, 1);
    predict(b, 1);
    @(posedge clk);
    cfg[0] <= a;
    cfg[3] <= b;
    waitDone(3, 20000);
    verifyMemory("priority pair");
    checkCount("first done channel", 14'd0, dmaPkg::unitCount_t'(doneOrder[0]));
    checkCount("channel 0 done", 14'd1, dmaPkg::unitCount_t'(doneCount[0]));

    a = makeCfg(1'b1, dmaPkg::startVblank, dmaPkg::stepInc, dmaPkg::stepIncReload, 1'b1,
      1'b1, 1 + int'($urandom_range(15)), 28'h0f0_0000, 28'h100_0000);
    clearTracking();
    fillSource(a.srcAddr);
    predict(a, 2);
    @(posedge clk);
    cfg[1] <= a;
    waitIrqs(1, 2, 200000);
    repeat (20) @(posedge clk);
    checkCount("repeat irq", 14'd2, dmaPkg::unitCount_t'(irqCount[1]));
    checkCount("repeat done", 14'd0, dmaPkg::unitCount_t'(doneCount[1]));
    cfg[1].enable <= 1'b0;
    repeat (4) @(posedge clk);
    verifyMemory("repeat reload");
    @(negedge clk);
    checkAddr("idle bus address", '0, bus.addr);
    checkCount("idle active channels", 14'd0, dmaPkg::unitCount_t'($countones(active)));
    checkCount("idle busActive", 14'd0, dmaPkg::unitCount_t'(busActive));

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== verilog/dmaController.sv ====
`timescale 1ns/1ns

module dmaController (
  input  logic                           clk,
  input  logic                           rst_b,
  input  dmaPkg::dmaCfg_t                cfg [dmaPkg::numChannels],
  input  dmaPkg::screenPos_t             hcount,
  input  dmaPkg::screenPos_t             vcount,
  input  logic                           memWait,
  input  dmaPkg::dmaWord_t               rdata,
  output dmaPkg::busReq_t                bus,
  output logic                           busActive,
  output logic [dmaPkg::numChannels-1:0] irq,
  output logic [dmaPkg::numChannels-1:0] done,
  output logic [dmaPkg::numChannels-1:0] active
);

  dmaPkg::busReq_t                chanReq [dmaPkg::numChannels];
  logic [dmaPkg::numChannels-1:0] midUnit;
  logic [dmaPkg::numChannels-1:0] preempted;
  logic                           allowedToBegin;

  for (genvar i = 0; i < dmaPkg::numChannels; i++) begin : gChannel
    dmaChannel uChannel (
      .clk, .rst_b,
      .cfg            (cfg[i]),
      .hcount, .vcount, .memWait,
      .preempted      (preempted[i]),
      .allowedToBegin,
      .rdata,
      .req            (chanReq[i]),
      .active         (active[i]),
      .midUnit        (midUnit[i]),
      .irq            (irq[i]),
      .done           (done[i])
    );
  end

  dmaBusArbiter uArbiter (
    .req (chanReq),
    .active, .midUnit, .preempted, .allowedToBegin, .bus, .busActive
  );

endmodule

// ==== verilog/dmaBusArbiter.sv ====
`timescale 1ns/1ns

module dmaBusArbiter (
  input  dmaPkg::busReq_t                 req [dmaPkg::numChannels],
  input  logic [dmaPkg::numChannels-1:0] active,
  input  logic [dmaPkg::numChannels-1:0] midUnit,
  output logic [dmaPkg::numChannels-1:0] preempted,
  output logic                           allowedToBegin,
  output dmaPkg::busReq_t                 bus,
  output logic                           busActive
);

  logic [dmaPkg::numChannels-1:0] lowerActive; // running OR from channel 0 up

  // channel 0 is never preempted
  always_comb begin
    lowerActive[0] = active[0];
    preempted[0]   = 1'b0;
    for (int i = 1; i < dmaPkg::numChannels; i++) begin
      preempted[i]   = lowerActive[i-1];
      lowerActive[i] = lowerActive[i-1] | active[i];
    end
  end

  assign allowedToBegin = ~|midUnit;
  assign busActive      = lowerActive[dmaPkg::numChannels-1];

  // walk down so the lowest active channel is the last one written
  always_comb begin
    bus = '0;
    for (int i = dmaPkg::numChannels - 1; i >= 0; i--) begin
      if (active[i]) bus = req[i];
    end
  end

  // only one channel may sit between its read and its write
  always_comb begin
    midUnitOwner: assert final ($onehot0(midUnit))
      else $error("more than one channel inside a unit: %b", midUnit);
  end

endmodule

// ==== verilog/dmaChannel.sv ====
`timescale 1ns/1ns

module dmaChannel (
  input  logic               clk,
  input  logic               rst_b,
  input  dmaPkg::dmaCfg_t    cfg,
  input  dmaPkg::screenPos_t hcount,
  input  dmaPkg::screenPos_t vcount,
  input  logic               memWait,
  input  logic               preempted,
  input  logic               allowedToBegin,
  input  dmaPkg::dmaWord_t   rdata,
  output dmaPkg::busReq_t    req,
  output logic               active,
  output logic               midUnit,
  output logic               irq,
  output logic               done
);

  logic blankHit;
  logic blankHitQ;
  logic start;
  logic restart;
  logic loadRegs;
  logic stepSrc;
  logic stepDst;
  logic storeRData;
  logic writePhase;
  logic xferDone;

  always_comb begin
    case (cfg.startMode)
      dmaPkg::startVblank: blankHit = (vcount == dmaPkg::screenPos_t'(dmaPkg::vblankLine));
      dmaPkg::startHblank: blankHit = (hcount == dmaPkg::screenPos_t'(dmaPkg::hblankCol));
      default:             blankHit = 1'b0;
    endcase
  end

  // one trigger per blank, however long the position is held
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) blankHitQ <= 1'b0;
    else        blankHitQ <= blankHit;
  end

  assign start = (cfg.startMode == dmaPkg::startNow) || (blankHit && !blankHitQ);

  // begin cycle with a finished count is a repeat pass
  assign restart = active && !midUnit && xferDone;

  dmaSequencer uSequencer (
    .clk, .rst_b, .cfg, .start, .memWait, .preempted, .allowedToBegin, .xferDone,
    .loadRegs, .stepSrc, .stepDst, .storeRData, .writePhase,
    .active, .midUnit, .irq, .done
  );

  dmaAddressPath uAddressPath (
    .clk, .rst_b, .cfg, .loadRegs, .restart, .stepSrc, .stepDst, .storeRData,
    .writePhase, .rdata, .req, .xferDone
  );

endmodule

// ==== verilog/dmaAddressPath.sv ====
`timescale 1ns/1ns

module dmaAddressPath (
  input  logic             clk,
  input  logic             rst_b,
  input  dmaPkg::dmaCfg_t  cfg,
  input  logic             loadRegs,
  input  logic             restart,
  input  logic             stepSrc,
  input  logic             stepDst,
  input  logic             storeRData,
  input  logic             writePhase,
  input  dmaPkg::dmaWord_t rdata,
  output dmaPkg::busReq_t  req,
  output logic             xferDone
);

  dmaPkg::dmaAddr_t   srcAddr;
  dmaPkg::dmaAddr_t   dstAddr;
  dmaPkg::dmaAddr_t   unitBytes;
  dmaPkg::unitCount_t units;
  dmaPkg::dmaWord_t   dataReg;
  dmaPkg::dmaWord_t   laneData;

  function automatic dmaPkg::dmaAddr_t stepAddr(input dmaPkg::dmaAddr_t addr,
                                                input dmaPkg::stepMode_t mode,
                                                input dmaPkg::dmaAddr_t delta);
    case (mode)
      dmaPkg::stepDec:   return addr - delta;
      dmaPkg::stepFixed: return addr;
      default:           return addr + delta; // inc and inc with reload
    endcase
  endfunction

  assign unitBytes = cfg.wordUnits ? dmaPkg::dmaAddr_t'(4) : dmaPkg::dmaAddr_t'(2);

  always_ff @(posedge clk) begin
    if (loadRegs) begin
      srcAddr <= cfg.srcAddr;
    end else if (stepSrc) begin
      srcAddr <= stepAddr(srcAddr, cfg.srcStep, unitBytes);
    end
  end

  always_ff @(posedge clk) begin
    if (loadRegs) begin
      dstAddr <= cfg.dstAddr;
    end else if (restart && cfg.dstStep == dmaPkg::stepIncReload) begin
      dstAddr <= cfg.dstAddr;  // repeat pass writes the same block again
    end else if (stepDst) begin
      dstAddr <= stepAddr(dstAddr, cfg.dstStep, unitBytes);
    end
  end

  // counts completed reads
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      units <= '0;
    end else if (loadRegs || restart) begin
      units <= '0;
    end else if (stepSrc) begin
      units <= units + dmaPkg::unitCount_t'(1);
    end
  end

  assign xferDone = (units == cfg.wordCount);

  always_ff @(posedge clk) begin
    if (storeRData) dataReg <= rdata;
  end

  // a halfword bound for the upper lane moves to bits 31:16
  always_comb begin
    laneData = dataReg;
    if (!cfg.wordUnits && dstAddr[1]) begin
      laneData[31:16] = dataReg[15:0];
    end
  end

  always_comb begin
    req.addr  = writePhase ? dstAddr : srcAddr;
    req.wdata = writePhase ? laneData : '0;
    req.size  = cfg.wordUnits ? dmaPkg::sizeWord : dmaPkg::sizeHalf;
    req.wen   = writePhase;
  end

  countNonZero: assert property (@(posedge clk) disable iff (!rst_b)
    loadRegs |-> (cfg.wordCount != '0))
    else $error("channel enabled with a zero unit count");

endmodule

// ==== verilog/dmaSequencer.sv ====
`timescale 1ns/1ns

module dmaSequencer (
  input  logic            clk,
  input  logic            rst_b,
  input  dmaPkg::dmaCfg_t cfg,
  input  logic            start,
  input  logic            memWait,
  input  logic            preempted,
  input  logic            allowedToBegin,
  input  logic            xferDone,
  output logic            loadRegs,
  output logic            stepSrc,
  output logic            stepDst,
  output logic            storeRData,
  output logic            writePhase,
  output logic            active,
  output logic            midUnit,
  output logic            irq,
  output logic            done
);

  dmaPkg::seqState_t state;
  dmaPkg::seqState_t nextState;
  logic canBegin;
  logic beginXfer;
  logic readDone;
  logic writeDone;
  logic lastWrite;

  // a channel only takes the bus when nobody is inside a unit
  assign canBegin = cfg.enable && !preempted && !memWait && allowedToBegin;

  assign readDone  = (state == dmaPkg::stRead) && !memWait;
  assign writeDone = (state == dmaPkg::stWrite) && !memWait;
  assign lastWrite = writeDone && xferDone;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= dmaPkg::stOff;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    loadRegs  = 1'b0;
    beginXfer = 1'b0;
    case (state)
      dmaPkg::stOff: begin
        if (cfg.enable) begin
          loadRegs  = 1'b1;
          nextState = dmaPkg::stIdle;
        end
      end
      dmaPkg::stIdle: begin
        if (!cfg.enable) begin
          nextState = dmaPkg::stOff;
        end else if (start) begin
          if (canBegin) begin
            beginXfer = 1'b1;
            nextState = dmaPkg::stRead;
          end else begin
            nextState = dmaPkg::stQueued; // hold the trigger until the bus frees up
          end
        end
      end
      dmaPkg::stQueued, dmaPkg::stPreempted: begin
        if (!cfg.enable) begin
          nextState = dmaPkg::stOff;
        end else if (canBegin) begin
          beginXfer = 1'b1;
          nextState = dmaPkg::stRead;
        end
      end
      dmaPkg::stRead: begin
        if (!memWait) nextState = dmaPkg::stWrite;
      end
      dmaPkg::stWrite: begin
        if (!memWait) begin
          if (xferDone) begin
            nextState = cfg.repeatEn ? dmaPkg::stIdle : dmaPkg::stOff;
          end else if (!cfg.enable) begin
            nextState = dmaPkg::stOff;
          end else if (preempted) begin
            nextState = dmaPkg::stPreempted; // yield between units
          end else begin
            nextState = dmaPkg::stRead;
          end
        end
      end
      default: nextState = dmaPkg::stOff;
    endcase
  end

  assign stepSrc    = readDone;
  assign storeRData = readDone;
  assign stepDst    = writeDone && !xferDone;
  assign writePhase = (state == dmaPkg::stWrite);

  // midUnit covers every real bus cycle, active adds the begin cycle
  assign midUnit = (state == dmaPkg::stRead) || (state == dmaPkg::stWrite);
  assign active  = beginXfer || midUnit;

  assign irq  = lastWrite && cfg.irqEnable;
  assign done = lastWrite && !cfg.repeatEn;

  stepExclusive: assert property (@(posedge clk) disable iff (!rst_b)
    !(stepSrc && stepDst))
    else $error("source and destination stepped in one cycle");

endmodule

// ==== verilog/dmaPkg.sv ====
package dmaPkg;

  localparam int numChannels = 4;
  localparam int addrWidth   = 28;
  localparam int countWidth  = 14;

  // screen positions that fire the blank triggers
  localparam int hblankCol  = 240;
  localparam int vblankLine = 160;

  typedef logic [addrWidth-1:0]  dmaAddr_t;   // byte address
  typedef logic [31:0]           dmaWord_t;
  typedef logic [countWidth-1:0] unitCount_t;
  typedef logic [7:0]            screenPos_t; // hcount or vcount

  typedef enum logic [1:0] {
    stepInc       = 2'd0,
    stepDec       = 2'd1,
    stepFixed     = 2'd2,
    stepIncReload = 2'd3  // destination only, reloads on repeat
  } stepMode_t;

  typedef enum logic [1:0] {
    startNow     = 2'd0,
    startVblank  = 2'd1,
    startHblank  = 2'd2,
    startSpecial = 2'd3   // never starts a channel
  } startMode_t;

  // encoding is what memory sees on the size lines
  typedef enum logic [1:0] {
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } xferSize_t;

  typedef struct packed {
    logic       enable;
    logic       irqEnable;
    logic       repeatEn;
    logic       wordUnits;
    startMode_t startMode;
    stepMode_t  srcStep;
    stepMode_t  dstStep;
    unitCount_t wordCount;
    dmaAddr_t   srcAddr;
    dmaAddr_t   dstAddr;
  } dmaCfg_t;

  typedef struct packed {
    dmaAddr_t  addr;
    dmaWord_t  wdata;
    xferSize_t size;
    logic      wen;
  } busReq_t;

  typedef enum logic [2:0] {
    stOff,
    stIdle,
    stQueued,
    stRead,
    stWrite,
    stPreempted
  } seqState_t;

endpackage
